// ==== Bender.yml ====
package:
  name: icache

sources:
  - hdl/cachePkg.sv
  - hdl/refillBuffer.sv
  - hdl/lineArray.sv
  - hdl/cacheCtrl.sv
  - hdl/icacheTop.sv
  - target: test
    files:
      - verif/cache_properties.sv
      - verif/tbIcache.sv

// ==== hdl/cacheCtrl.sv ====
module cacheCtrl import cachePkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       reqValid_i,
  input  addrT       reqAddr_i,
  input  logic       memRdReady_i,
  input  logic       lineDone_i,
  input  lineT       rdLine0_i,
  input  lineT       rdLine1_i,
  output logic       addrOk_o,
  output logic       dataOk_o,
  output logic       dataNotOk_o,
  output wordT       rdData_o,
  output logic       memRdValid_o,
  output addrT       memAddr_o,
  output logic [7:0] memLen_o,
  output logic       arrRdEn_o,
  output indexT      arrRdIndex_o,
  output logic       arrWrEn_o,
  output logic       arrWrWay_o,
  output indexT      arrWrIndex_o
);

  ctrlStateT state;
  ctrlStateT stateNext;

  // accepted request, payload only
  addrT reqQ;
  tagT reqTag;
  indexT reqIndex;

  // tag and valid per way, victim bit per set
  tagT tag0Arr [SETS];
  tagT tag1Arr [SETS];
  logic [SETS-1:0] valid0Arr;
  logic [SETS-1:0] valid1Arr;
  logic [SETS-1:0] victimArr;

  logic accept;
  logic way0Hit;
  logic way1Hit;
  logic hit;
  lineT hitLine;
  logic fillWay;
  logic refillWr;
  // line written last cycle, array read can go now
  logic refillWrQ;

  assign reqTag = reqQ[ADDR_W-1 -: TAG_W];
  assign reqIndex = reqQ[OFFSET_W +: INDEX_W];

  // tag compare against the latched request
  assign way0Hit = valid0Arr[reqIndex] && (tag0Arr[reqIndex] == reqTag);
  assign way1Hit = valid1Arr[reqIndex] && (tag1Arr[reqIndex] == reqTag);
  assign hit = (state == stCompare) && (way0Hit || way1Hit);

  // new request in idle or alongside a hit
  assign addrOk_o = (state == stIdle) || hit;
  assign accept = reqValid_i && addrOk_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= stIdle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    unique case (state)
      stIdle: begin
        if (accept) begin
          stateNext = stCompare;
        end
      end
      stCompare: begin
        if (!hit) begin
          stateNext = stMiss;
        end else if (!accept) begin
          stateNext = stIdle;
        end
      end
      stMiss: begin
        // memory ready is the only back-pressure
        if (memRdReady_i) begin
          stateNext = stRefill;
        end
      end
      stRefill: begin
        // re-read the written line, then compare again
        if (refillWrQ) begin
          stateNext = stCompare;
        end
      end
      default: begin
        stateNext = stIdle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= reqAddr_i;
    end
  end

  // word select by address bits 4 and 3
  assign hitLine = way1Hit ? rdLine1_i : rdLine0_i;
  assign dataOk_o = hit;
  assign rdData_o = hit ? hitLine[reqQ[OFFSET_W-1:3]*WORD_W +: WORD_W] : '0;
  assign dataNotOk_o = ((state == stCompare) && !hit) || (state == stMiss)
                    || (state == stRefill);

  // burst request, one cycle per miss
  assign memRdValid_o = (state == stMiss) && memRdReady_i;
  assign memAddr_o = {reqTag, reqIndex, {OFFSET_W{1'b0}}};
  assign memLen_o = 8'(BEATS - 1);

  // invalid way first, else the set's victim bit
  assign fillWay = !valid0Arr[reqIndex] ? 1'b0
                 : !valid1Arr[reqIndex] ? 1'b1
                 : victimArr[reqIndex];
  assign refillWr = (state == stRefill) && lineDone_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      refillWrQ <= 1'b0;
    end else begin
      refillWrQ <= refillWr;
    end
  end

  // valid and victim bits, flip victim on every refill of the set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid0Arr <= '0;
      valid1Arr <= '0;
      victimArr <= '0;
    end else if (refillWr) begin
      if (fillWay) begin
        valid1Arr[reqIndex] <= 1'b1;
      end else begin
        valid0Arr[reqIndex] <= 1'b1;
      end
      victimArr[reqIndex] <= ~victimArr[reqIndex];
    end
  end

  always_ff @(posedge clk) begin
    if (refillWr && !fillWay) begin
      tag0Arr[reqIndex] <= reqTag;
    end
    if (refillWr && fillWay) begin
      tag1Arr[reqIndex] <= reqTag;
    end
  end

  // array read for a new request or after the refill write
  assign arrRdEn_o = accept || ((state == stRefill) && refillWrQ);
  assign arrRdIndex_o = (state == stRefill) ? reqIndex : reqAddr_i[OFFSET_W +: INDEX_W];
  assign arrWrEn_o = refillWr;
  assign arrWrWay_o = fillWay;
  assign arrWrIndex_o = reqIndex;

endmodule

// ==== hdl/cachePkg.sv ====
package cachePkg;

  // address and data widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 64;
  localparam int LINE_W = 256;

  // two ways of 64 sets, 32-byte lines
  localparam int SETS = 64;
  localparam int INDEX_W = 6;
  localparam int OFFSET_W = 5;
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  // beats per refill burst, one word each
  localparam int BEATS = LINE_W / WORD_W;

  typedef logic [ADDR_W-1:0] addrT;
  typedef logic [WORD_W-1:0] wordT;
  // beat 0 sits in the low word
  typedef logic [LINE_W-1:0] lineT;
  typedef logic [TAG_W-1:0] tagT;
  typedef logic [INDEX_W-1:0] indexT;
  typedef logic [$clog2(BEATS)-1:0] beatCntT;

  // controller states
  // idle waits for a request, compare checks tags on the array output
  // miss waits for the memory port, refill collects and writes the line
  typedef enum logic [1:0] {
    stIdle,
    stCompare,
    stMiss,
    stRefill
  } ctrlStateT;

endpackage

// ==== hdl/icacheTop.sv ====
module icacheTop import cachePkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // fetch stage side
  input  logic       reqValid_i,
  input  addrT       reqAddr_i,
  output logic       addrOk_o,
  output logic       dataOk_o,
  output logic       dataNotOk_o,
  output wordT       rdData_o,
  // burst read port
  output logic       memRdValid_o,
  input  logic       memRdReady_i,
  output addrT       memAddr_o,
  output logic [7:0] memLen_o,
  input  wordT       memData_i,
  input  logic       memDataValid_i,
  input  logic       memRdLast_i
);

  lineT refillLine;
  logic lineDone;
  logic arrRdEn;
  indexT arrRdIndex;
  logic arrWrEn;
  logic arrWrWay;
  indexT arrWrIndex;
  lineT rdLine0;
  lineT rdLine1;

  // memory beats into a full line
  refillBuffer u_refill (
    .clk            (clk),
    .rst_n          (rst_n),
    .memData_i      (memData_i),
    .memDataValid_i (memDataValid_i),
    .memRdLast_i    (memRdLast_i),
    .refillLine_o   (refillLine),
    .lineDone_o     (lineDone)
  );

  // data storage, refill line is the only write source
  lineArray u_lines (
    .clk       (clk),
    .rdEn_i    (arrRdEn),
    .rdIndex_i (arrRdIndex),
    .wrEn_i    (arrWrEn),
    .wrWay_i   (arrWrWay),
    .wrIndex_i (arrWrIndex),
    .wrLine_i  (refillLine),
    .rdLine0_o (rdLine0),
    .rdLine1_o (rdLine1)
  );

  cacheCtrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqValid_i   (reqValid_i),
    .reqAddr_i    (reqAddr_i),
    .memRdReady_i (memRdReady_i),
    .lineDone_i   (lineDone),
    .rdLine0_i    (rdLine0),
    .rdLine1_i    (rdLine1),
    .addrOk_o     (addrOk_o),
    .dataOk_o     (dataOk_o),
    .dataNotOk_o  (dataNotOk_o),
    .rdData_o     (rdData_o),
    .memRdValid_o (memRdValid_o),
    .memAddr_o    (memAddr_o),
    .memLen_o     (memLen_o),
    .arrRdEn_o    (arrRdEn),
    .arrRdIndex_o (arrRdIndex),
    .arrWrEn_o    (arrWrEn),
    .arrWrWay_o   (arrWrWay),
    .arrWrIndex_o (arrWrIndex)
  );

endmodule

// ==== hdl/lineArray.sv ====
module lineArray import cachePkg::*; (
  input  logic    clk,
  input  logic    rdEn_i,
  input  indexT   rdIndex_i,
  input  logic    wrEn_i,
  input  logic    wrWay_i,
  input  indexT   wrIndex_i,
  input  lineT    wrLine_i,
  output lineT    rdLine0_o,
  output lineT    rdLine1_o
);

  // one 256-bit line per set in each way
  lineT way0Mem [SETS];
  lineT way1Mem [SETS];
  lineT rdLine0Q;
  lineT rdLine1Q;

  // synchronous read of both ways at once
  // same-cycle write to that index is not seen yet
  always_ff @(posedge clk) begin
    if (rdEn_i) begin
      rdLine0Q <= way0Mem[rdIndex_i];
      rdLine1Q <= way1Mem[rdIndex_i];
    end
  end

  // write goes to the selected way only
  always_ff @(posedge clk) begin
    if (wrEn_i && !wrWay_i) begin
      way0Mem[wrIndex_i] <= wrLine_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wrEn_i && wrWay_i) begin
      way1Mem[wrIndex_i] <= wrLine_i;
    end
  end

  // read data holds until the next read
  assign rdLine0_o = rdLine0Q;
  assign rdLine1_o = rdLine1Q;

endmodule

// ==== hdl/refillBuffer.sv ====
module refillBuffer import cachePkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  wordT    memData_i,
  input  logic    memDataValid_i,
  input  logic    memRdLast_i,
  output lineT    refillLine_o,
  output logic    lineDone_o
);

  // slot of the next beat
  beatCntT beatCnt;
  // line under assembly
  lineT lineQ;
  logic doneQ;

  // beat position wraps to zero after the last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (memDataValid_i) begin
      if (memRdLast_i) begin
        // a short burst also closes the line
        beatCnt <= '0;
      end else begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  // each valid beat lands in its own word slot
  always_ff @(posedge clk) begin
    if (memDataValid_i) begin
      lineQ[beatCnt*WORD_W +: WORD_W] <= memData_i;
    end
  end

  // one-cycle pulse after the last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      doneQ <= 1'b0;
    end else begin
      doneQ <= memDataValid_i && memRdLast_i;
    end
  end

  assign refillLine_o = lineQ;
  assign lineDone_o = doneQ;

endmodule

// ==== list.f ====
hdl/cachePkg.sv
hdl/refillBuffer.sv
hdl/lineArray.sv
hdl/cacheCtrl.sv
hdl/icacheTop.sv
verif/cache_properties.sv
verif/tbIcache.sv

// ==== verif/cache_properties.sv ====
module cacheProps import cachePkg::*; (
  input logic      clk,
  input logic      rst_n,
  input ctrlStateT state_i,
  input logic      addrOk_i,
  input logic      dataOk_i,
  input logic      dataNotOk_i,
  input logic      memRdValid_i,
  input addrT      memAddr_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // read by the testbench top
  int failCnt = 0;

  // burst request is a single-cycle strobe
  reqPulse: assert property (@(posedge clk) disable iff (!rst_n)
    memRdValid_i |=> !memRdValid_i)
    else begin
      $error("memRdValid_o high for two cycles");
      failCnt++;
    end

  okExclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(dataOk_i && dataNotOk_i))
    else begin
      $error("dataOk_o and dataNotOk_o high together");
      failCnt++;
    end

  // no new request while a miss is served
  noAcceptInMiss: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i inside {stMiss, stRefill}) |-> !addrOk_i)
    else begin
      $error("addrOk_o high during a miss");
      failCnt++;
    end

  lineAligned: assert property (@(posedge clk) disable iff (!rst_n)
    memRdValid_i |-> (memAddr_i[OFFSET_W-1:0] == '0))
    else begin
      $error("burst address not line aligned");
      failCnt++;
    end

endmodule

// ==== verif/tbIcache.sv ====
module tbIcache import cachePkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RAND_REQ = 200;
  localparam int TOTAL_REQ = 3 + BEATS + 8 + 7 + RAND_REQ;
  localparam int CYCLES_PER_REQ = 200;

  // cold lines in sets 0, 33 and 63
  localparam addrT COLD_ADDR [3] = '{32'h0000_1008, 32'h0000_2430, 32'h0004_7ff8};
  // hits across the three cold lines at mixed offsets
  localparam addrT B2B_ADDR [8] = '{
    32'h0000_1000, 32'h0000_2438, 32'h0004_7fe0, 32'h0000_1018,
    32'h0000_2420, 32'h0004_7ff8, 32'h0000_1010, 32'h0000_2428
  };
  // three tags in set 5
  // A and B fill both ways, C evicts A, then B hits and A misses
  localparam addrT SET_SEQ [7] = '{
    32'h0001_00a0, 32'h0002_00a0, 32'h0001_00a8, 32'h0002_00b8,
    32'h0003_00a0, 32'h0002_00a8, 32'h0001_00b0
  };

  logic clk;
  logic rst_n;
  logic reqValid;
  addrT reqAddr;
  logic addrOk;
  logic dataOk;
  logic dataNotOk;
  wordT rdData;
  logic memRdValid;
  logic memRdReady;
  addrT memAddr;
  logic [7:0] memLen;
  wordT memData;
  logic memDataValid;
  logic memRdLast;

  int seed = 32'h6670_9917;

  // accepted requests, oldest first
  addrT addrQ [$];
  logic hitQ [$];
  int cycQ [$];

  // reference copy of tag, valid and victim state
  logic refValid [2][SETS];
  tagT refTag [2][SETS];
  logic refVictim [SETS];

  logic missSeen = 1'b0;
  int cycleCnt = 0;
  int issuedCnt = 0;
  int doneCnt = 0;

  icacheTop u_icacheTop (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (reqValid),
    .reqAddr_i      (reqAddr),
    .addrOk_o       (addrOk),
    .dataOk_o       (dataOk),
    .dataNotOk_o    (dataNotOk),
    .rdData_o       (rdData),
    .memRdValid_o   (memRdValid),
    .memRdReady_i   (memRdReady),
    .memAddr_o      (memAddr),
    .memLen_o       (memLen),
    .memData_i      (memData),
    .memDataValid_i (memDataValid),
    .memRdLast_i    (memRdLast)
  );

  bind cacheCtrl cacheProps u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .state_i      (state),
    .addrOk_i     (addrOk_o),
    .dataOk_i     (dataOk_o),
    .dataNotOk_i  (dataNotOk_o),
    .memRdValid_i (memRdValid_o),
    .memAddr_i    (memAddr_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // memory contents mixed from the word address
  function automatic wordT memWord(addrT a);
    logic [31:0] wa;
    wa = a >> 3;
    return ({32'h0, wa} * 64'h9e37_79b9_7f4a_7c15) ^ {~wa, wa};
  endfunction

  function automatic int randBelow(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // tags 0..3 in sets 0..3 at any word
  function automatic addrT randAddr();
    addrT a;
    a = addrT'(randBelow(4)) << 11;
    a = a | (addrT'(randBelow(4)) << 5);
    a = a | (addrT'(randBelow(4)) << 3);
    return a;
  endfunction

  // predicts hit or miss and fills the model on a miss
  function automatic logic predictHit(addrT a);
    tagT t;
    indexT idx;
    logic way;
    t = a[ADDR_W-1 -: TAG_W];
    idx = a[OFFSET_W +: INDEX_W];
    if (refValid[0][idx] && refTag[0][idx] == t) begin
      return 1'b1;
    end
    if (refValid[1][idx] && refTag[1][idx] == t) begin
      return 1'b1;
    end
    // invalid way first, else victim bit
    if (!refValid[0][idx]) begin
      way = 1'b0;
    end else if (!refValid[1][idx]) begin
      way = 1'b1;
    end else begin
      way = refVictim[idx];
    end
    refValid[way][idx] = 1'b1;
    refTag[way][idx] = t;
    refVictim[idx] = ~refVictim[idx];
    return 1'b0;
  endfunction

  task automatic reportFail(string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  // hold the request until the cache takes it
  task automatic issueReq(addrT a, output int waits);
    reqValid <= 1'b1;
    reqAddr <= a;
    issuedCnt++;
    waits = 0;
    do begin
      @(posedge clk);
      waits++;
    end while (!addrOk);
  endtask

  task automatic waitIdle();
    reqValid <= 1'b0;
    do begin
      @(posedge clk);
    end while (doneCnt != issuedCnt);
  endtask

  initial begin : stimulus
    int waits;
    int i;
    reqValid = 1'b0;
    reqAddr = '0;
    rst_n = 1'b0;
    for (i = 0; i < SETS; i++) begin
      refValid[0][i] = 1'b0;
      refValid[1][i] = 1'b0;
      refVictim[i] = 1'b0;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    // first touch of each line
    for (i = 0; i < 3; i++) begin
      issueReq(COLD_ADDR[i], waits);
      waitIdle();
    end
    // every word of one resident line
    for (i = 0; i < BEATS; i++) begin
      issueReq(32'h0000_1000 + addrT'(i * 8), waits);
      waitIdle();
    end
    // reqValid held high over resident lines
    for (i = 0; i < 8; i++) begin
      issueReq(B2B_ADDR[i], waits);
      assert (waits == 1)
        else reportFail("back-to-back hit request was not accepted on the next cycle");
    end
    waitIdle();
    for (i = 0; i < 7; i++) begin
      issueReq(SET_SEQ[i], waits);
      waitIdle();
    end
    // random stream with idle gaps
    for (i = 0; i < RAND_REQ; i++) begin
      if (randBelow(3) == 0) begin
        reqValid <= 1'b0;
        repeat (1 + randBelow(3)) @(posedge clk);
      end
      issueReq(randAddr(), waits);
    end
    waitIdle();
    if (u_icacheTop.u_ctrl.u_props.failCnt == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1);
    end
  end

  // burst answers with a random start gap and beat bubbles
  initial begin : memModel
    addrT base;
    addrT expAddr;
    int beat;
    memRdReady = 1'b0;
    memData = '0;
    memDataValid = 1'b0;
    memRdLast = 1'b0;
    wait (rst_n);
    forever begin
      @(posedge clk);
      if (memRdValid) begin
        assert (addrQ.size() == 1) else reportFail("burst request with no miss outstanding");
        base = memAddr;
        expAddr = {addrQ[0][ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        assert (memAddr == expAddr)
          else reportFail($sformatf("FAIL memAddr_o got %h expected %h", memAddr, expAddr));
        assert (memLen == 8'd3)
          else reportFail($sformatf("FAIL memLen_o got %h expected %h", memLen, 8'd3));
        repeat (randBelow(6)) begin
          memRdReady <= randBelow(2) == 1;
          @(posedge clk);
        end
        beat = 0;
        while (beat < BEATS) begin
          if (randBelow(3) == 0) begin
            memDataValid <= 1'b0;
            memRdLast <= 1'b0;
          end else begin
            memDataValid <= 1'b1;
            memData <= memWord(base + addrT'(beat * 8));
            memRdLast <= beat == BEATS - 1;
            beat++;
          end
          memRdReady <= randBelow(2) == 1;
          @(posedge clk);
        end
        memDataValid <= 1'b0;
        memRdLast <= 1'b0;
      end else begin
        memRdReady <= randBelow(2) == 1;
      end
    end
  end

  // outputs sampled on the edge before the DUT updates
  always @(posedge clk) begin : compare
    addrT a;
    wordT expData;
    logic expHit;
    int lat;
    if (rst_n) begin
      cycleCnt = cycleCnt + 1;
      assert (u_icacheTop.u_ctrl.u_props.failCnt == 0)
        else reportFail("a protocol assertion on the cache controller failed");
      if (dataOk) begin
        assert (addrQ.size() > 0) else reportFail("dataOk_o pulsed with no request outstanding");
        a = addrQ.pop_front();
        expHit = hitQ.pop_front();
        lat = cycleCnt - cycQ.pop_front();
        expData = memWord({a[ADDR_W-1:3], 3'b000});
        assert (rdData === expData)
          else reportFail($sformatf("FAIL rdData_o at %h got %h expected %h", a, rdData, expData));
        assert (missSeen == !expHit)
          else reportFail($sformatf("FAIL dataNotOk_o at %h seen %h expected %h",
                                    a, missSeen, !expHit));
        // hit answers in the next cycle
        if (expHit) begin
          assert (lat == 1)
            else reportFail($sformatf("FAIL dataOk_o latency at %h got %h expected %h",
                                      a, lat, 1));
        end
        missSeen = 1'b0;
        doneCnt <= doneCnt + 1;
      end
      if (dataNotOk) begin
        missSeen = 1'b1;
      end
      if (reqValid && addrOk) begin
        addrQ.push_back(reqAddr);
        hitQ.push_back(predictHit(reqAddr));
        cycQ.push_back(cycleCnt);
      end
    end
  end

  initial begin : watchdog
    repeat (TOTAL_REQ * CYCLES_PER_REQ + 20) @(posedge clk);
    reportFail($sformatf("Timeout: run did not finish within %0d cycles",
                         TOTAL_REQ * CYCLES_PER_REQ + 20));
  end

endmodule
